// File: bounce_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// coordinate, position, pixel and TMDS symbol types
// plus the speed-load struct and TMDS control tokens
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package bounce_pkg;

    localparam int CORDW = 12;  // screen coordinate width in bits

    typedef logic [CORDW-1:0] coord_t;

    // top-left corner of a square
    typedef struct packed {
        coord_t x;
        coord_t y;
    } pos_t;

    // run-time speeds, one per square
    typedef struct packed {
        coord_t spd_red;
        coord_t spd_green;
        coord_t spd_blue;
    } speed_load_t;

    // registered DVI pixel ahead of the encoders
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
        logic       hsync;
        logic       vsync;
        logic       de;
    } dvi_pixel_t;

    typedef logic [9:0] tmds_sym_t;

    // control tokens sent during blanking, named by {c1, c0}
    localparam tmds_sym_t TMDS_CTRL_00 = 10'b1101010100;
    localparam tmds_sym_t TMDS_CTRL_01 = 10'b0010101011;
    localparam tmds_sym_t TMDS_CTRL_10 = 10'b0101010100;
    localparam tmds_sym_t TMDS_CTRL_11 = 10'b1010101011;

endpackage

// File: display_timings.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// display timing generator: pixel and line counters,
// sync, data enable and once-per-frame strobe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module display_timings import bounce_pkg::*; #(
    parameter int H_RES  = 1280,
    parameter int H_FP   = 110,
    parameter int H_SYNC = 40,
    parameter int H_BP   = 220,
    parameter int V_RES  = 720,
    parameter int V_FP   = 5,
    parameter int V_SYNC = 5,
    parameter int V_BP   = 20
) (
    input  logic   clk_pix,
    input  logic   reset,
    output coord_t sx,
    output coord_t sy,
    output logic   hsync,
    output logic   vsync,
    output logic   de,
    output logic   frame_stb
);

    localparam coord_t H_LAST = coord_t'(H_RES + H_FP + H_SYNC + H_BP - 1);
    localparam coord_t V_LAST = coord_t'(V_RES + V_FP + V_SYNC + V_BP - 1);
    localparam coord_t HS_STA = coord_t'(H_RES + H_FP);          // sync follows front porch
    localparam coord_t HS_END = coord_t'(H_RES + H_FP + H_SYNC);
    localparam coord_t VS_STA = coord_t'(V_RES + V_FP);
    localparam coord_t VS_END = coord_t'(V_RES + V_FP + V_SYNC);
    localparam coord_t HA_END = coord_t'(H_RES);
    localparam coord_t VA_END = coord_t'(V_RES);

    coord_t sx_nxt;
    coord_t sy_nxt;

    // next counter values, so the decoded outputs line up with sx/sy
    always_comb begin
        sx_nxt = sx + coord_t'(1);
        sy_nxt = sy;
        if (sx == H_LAST) begin
            sx_nxt = '0;
            sy_nxt = (sy == V_LAST) ? '0 : sy + coord_t'(1);
        end
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sx        <= '0;
            sy        <= '0;
            hsync     <= 1'b0;
            vsync     <= 1'b0;
            de        <= 1'b0;
            frame_stb <= 1'b0;
        end else begin
            sx        <= sx_nxt;
            sy        <= sy_nxt;
            hsync     <= (sx_nxt >= HS_STA) && (sx_nxt < HS_END);  // positive polarity
            vsync     <= (sy_nxt >= VS_STA) && (sy_nxt < VS_END);
            de        <= (sx_nxt < HA_END) && (sy_nxt < VA_END);
            frame_stb <= (sy_nxt == VA_END) && (sx_nxt == '0);     // first blanking pixel
        end
    end

    // animation must step exactly once per frame
    frame_stb_one_cycle: assert property (
        @(posedge clk_pix) disable iff (reset) frame_stb |=> !frame_stb
    );

endmodule

// File: square_mover.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one bouncing square: speed register, per-frame
// move with edge reflection and pixel hit test
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module square_mover import bounce_pkg::*; #(
    parameter int H_RES     = 1280,
    parameter int V_RES     = 720,
    parameter int SIZE      = 200,
    parameter int START_X   = 0,
    parameter int START_Y   = 0,
    parameter int START_SPD = 4
) (
    input  logic   clk_pix,
    input  logic   reset,
    input  logic   frame_stb,
    input  logic   speed_stb,
    input  coord_t speed,
    input  coord_t sx,
    input  coord_t sy,
    output pos_t   pos,
    output logic   hit
);

    localparam coord_t X_MAX = coord_t'(H_RES - SIZE);  // furthest legal top-left
    localparam coord_t Y_MAX = coord_t'(V_RES - SIZE);
    localparam coord_t SZ    = coord_t'(SIZE);

    typedef struct packed {
        logic   dir;  // 1 is up/left
        coord_t p;
    } axis_t;

    coord_t spd;    // step per frame
    logic   dir_x;
    logic   dir_y;
    axis_t  nxt_x;
    axis_t  nxt_y;

    // same edge rule on both axes
    function automatic axis_t step_axis(coord_t p, logic dir, coord_t s, coord_t lim);
        axis_t r;
        if (p >= lim - s) begin         // far edge
            r.dir = 1'b1;
            r.p   = p - s;
        end else if (p < s) begin       // near edge
            r.dir = 1'b0;
            r.p   = p + s;
        end else begin
            r.dir = dir;
            r.p   = dir ? p - s : p + s;
        end
        return r;
    endfunction

    always_comb begin
        nxt_x = step_axis(pos.x, dir_x, spd, X_MAX);
        nxt_y = step_axis(pos.y, dir_y, spd, Y_MAX);
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            pos.x <= coord_t'(START_X);
            pos.y <= coord_t'(START_Y);
            dir_x <= 1'b0;                  // right
            dir_y <= 1'b0;                  // down
            spd   <= coord_t'(START_SPD);
        end else begin
            if (speed_stb)
                spd <= speed;               // takes effect at next frame_stb
            if (frame_stb) begin
                pos.x <= nxt_x.p;
                pos.y <= nxt_y.p;
                dir_x <= nxt_x.dir;
                dir_y <= nxt_y.dir;
            end
        end
    end

    always_comb begin
        hit = (sx >= pos.x) && (sx < pos.x + SZ) && (sy >= pos.y) && (sy < pos.y + SZ);
    end

    // reflection keeps the square fully on screen
    pos_in_bounds: assert property (
        @(posedge clk_pix) disable iff (reset) (pos.x <= X_MAX) && (pos.y <= Y_MAX)
    );

endmodule

// File: pixel_composer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pixel composer: hit flags to registered DVI pixel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module pixel_composer import bounce_pkg::*; (
    input  logic       clk_pix,
    input  logic       reset,
    input  logic       hit_red,
    input  logic       hit_green,
    input  logic       hit_blue,
    input  logic       hsync,
    input  logic       vsync,
    input  logic       de,
    output dvi_pixel_t pix
);

    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;

    // colour is forced to black during blanking
    always_comb begin
        red   = (de && hit_red)   ? 8'hFF : 8'h00;
        green = (de && hit_green) ? 8'hFF : 8'h00;
        blue  = (de && hit_blue)  ? 8'hFF : 8'h00;
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            pix <= '0;
        end else begin
            pix.red   <= red;
            pix.green <= green;
            pix.blue  <= blue;
            pix.hsync <= hsync;     // keep sync aligned with colour
            pix.vsync <= vsync;
            pix.de    <= de;
        end
    end

endmodule

// File: tmds_encoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TMDS 8b/10b encoder for one DVI channel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module tmds_encoder import bounce_pkg::*; (
    input  logic       clk_pix,
    input  logic       reset,
    input  logic [7:0] data,
    input  logic [1:0] ctrl,
    input  logic       de,
    output tmds_sym_t  sym
);

    logic [3:0]        n1_d;       // ones in input byte
    logic [3:0]        n1_q;       // ones in q_m[7:0]
    logic              use_xnor;
    logic [8:0]        q_m;        // transition-minimised word
    logic signed [5:0] bal;        // ones minus zeros of q_m[7:0]
    logic signed [5:0] disp;       // running disparity
    tmds_sym_t         ctrl_sym;

    always_comb begin
        n1_d = '0;
        for (int i = 0; i < 8; i++)
            n1_d = n1_d + {3'b000, data[i]};
    end

    // stage 1: xor or xnor chain
    always_comb begin
        use_xnor = (n1_d > 4'd4) || ((n1_d == 4'd4) && !data[0]);
        q_m[0]   = data[0];
        for (int i = 1; i < 8; i++)
            q_m[i] = use_xnor ? ~(q_m[i-1] ^ data[i]) : (q_m[i-1] ^ data[i]);
        q_m[8]   = ~use_xnor;
    end

    always_comb begin
        n1_q = '0;
        for (int i = 0; i < 8; i++)
            n1_q = n1_q + {3'b000, q_m[i]};
        bal = $signed({1'b0, n1_q, 1'b0}) - 6'sd8;
    end

    always_comb begin
        case (ctrl)
            2'b00:   ctrl_sym = TMDS_CTRL_00;
            2'b01:   ctrl_sym = TMDS_CTRL_01;
            2'b10:   ctrl_sym = TMDS_CTRL_10;
            default: ctrl_sym = TMDS_CTRL_11;
        endcase
    end

    // stage 2: dc balance against running disparity
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sym  <= TMDS_CTRL_00;
            disp <= '0;
        end else if (!de) begin
            sym  <= ctrl_sym;
            disp <= '0;                 // blanking restarts the balance
        end else if ((disp == 0) || (bal == 0)) begin
            sym  <= {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
            disp <= q_m[8] ? disp + bal : disp - bal;
        end else if (((disp > 0) && (bal > 0)) || ((disp < 0) && (bal < 0))) begin
            sym  <= {1'b1, q_m[8], ~q_m[7:0]};   // invert to pull back
            disp <= disp + (q_m[8] ? 6'sd2 : 6'sd0) - bal;
        end else begin
            sym  <= {1'b0, q_m[8], q_m[7:0]};
            disp <= disp - (q_m[8] ? 6'sd0 : 6'sd2) + bal;
        end
    end

    // balance stays bounded across a whole line of data symbols
    disp_bounded: assert property (
        @(posedge clk_pix) disable iff (reset) (disp <= 8) && (disp >= -8) && !disp[0]
    );

endmodule

// File: bounce_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bouncing squares top: timings, three movers,
// pixel composer and three TMDS encoders
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module bounce_top import bounce_pkg::*; #(
    parameter int H_RES      = 1280,
    parameter int H_FP       = 110,
    parameter int H_SYNC     = 40,
    parameter int H_BP       = 220,
    parameter int V_RES      = 720,
    parameter int V_FP       = 5,
    parameter int V_SYNC     = 5,
    parameter int V_BP       = 20,
    parameter int RED_SIZE   = 200,
    parameter int GREEN_SIZE = 300,
    parameter int BLUE_SIZE  = 400,
    parameter int RED_X      = 0,
    parameter int RED_Y      = 0,
    parameter int GREEN_X    = 16,
    parameter int GREEN_Y    = 8,
    parameter int BLUE_X     = 32,
    parameter int BLUE_Y     = 16,
    parameter int RED_SPD    = 4,
    parameter int GREEN_SPD  = 2,
    parameter int BLUE_SPD   = 2
) (
    input  logic        clk_pix,
    input  logic        reset,
    input  logic        speed_stb,
    input  speed_load_t speed,
    output tmds_sym_t   tmds_ch0,
    output tmds_sym_t   tmds_ch1,
    output tmds_sym_t   tmds_ch2,
    output pos_t        pos_red,
    output pos_t        pos_green,
    output pos_t        pos_blue
);

    coord_t     sx;
    coord_t     sy;
    logic       hsync;
    logic       vsync;
    logic       de;
    logic       frame_stb;
    logic       hit_red;
    logic       hit_green;
    logic       hit_blue;
    dvi_pixel_t pix;

    display_timings #(
        .H_RES(H_RES), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_RES(V_RES), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) timings0 (
        .clk_pix, .reset, .sx, .sy, .hsync, .vsync, .de, .frame_stb
    );

    square_mover #(
        .H_RES(H_RES), .V_RES(V_RES), .SIZE(RED_SIZE),
        .START_X(RED_X), .START_Y(RED_Y), .START_SPD(RED_SPD)
    ) mover_red (
        .clk_pix, .reset, .frame_stb, .speed_stb, .speed(speed.spd_red),
        .sx, .sy, .pos(pos_red), .hit(hit_red)
    );

    square_mover #(
        .H_RES(H_RES), .V_RES(V_RES), .SIZE(GREEN_SIZE),
        .START_X(GREEN_X), .START_Y(GREEN_Y), .START_SPD(GREEN_SPD)
    ) mover_green (
        .clk_pix, .reset, .frame_stb, .speed_stb, .speed(speed.spd_green),
        .sx, .sy, .pos(pos_green), .hit(hit_green)
    );

    square_mover #(
        .H_RES(H_RES), .V_RES(V_RES), .SIZE(BLUE_SIZE),
        .START_X(BLUE_X), .START_Y(BLUE_Y), .START_SPD(BLUE_SPD)
    ) mover_blue (
        .clk_pix, .reset, .frame_stb, .speed_stb, .speed(speed.spd_blue),
        .sx, .sy, .pos(pos_blue), .hit(hit_blue)
    );

    pixel_composer composer0 (
        .clk_pix, .reset, .hit_red, .hit_green, .hit_blue,
        .hsync, .vsync, .de, .pix
    );

    // channel 0 carries both syncs as its control bits
    tmds_encoder enc_ch0 (
        .clk_pix, .reset, .data(pix.blue), .ctrl({pix.vsync, pix.hsync}),
        .de(pix.de), .sym(tmds_ch0)
    );

    tmds_encoder enc_ch1 (
        .clk_pix, .reset, .data(pix.green), .ctrl(2'b00),
        .de(pix.de), .sym(tmds_ch1)
    );

    tmds_encoder enc_ch2 (
        .clk_pix, .reset, .data(pix.red), .ctrl(2'b00),
        .de(pix.de), .sym(tmds_ch2)
    );

endmodule

// File: tb_bounce.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the bouncing squares top: trace-driven
// speed loads, TMDS decode, sync, colour and DC checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module tb_bounce import bounce_pkg::*; ();

    localparam int H_RES = 64;
    localparam int H_FP = 4;
    localparam int H_SYNC = 8;
    localparam int H_BP = 4;
    localparam int V_RES = 48;
    localparam int V_FP = 2;
    localparam int V_SYNC = 2;
    localparam int V_BP = 2;
    localparam int H_TOTAL = H_RES + H_FP + H_SYNC + H_BP;     // 80 cycles per line
    localparam int V_TOTAL = V_RES + V_FP + V_SYNC + V_BP;     // 54 lines per frame
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int CLK_PERIOD = 10;
    localparam int VBLANK_CYCLES = (V_TOTAL - V_RES) * H_TOTAL;

    logic        clk_pix = 1'b0;
    logic        reset;
    logic        speed_stb;
    speed_load_t speed;
    tmds_sym_t   tmds_ch0;
    tmds_sym_t   tmds_ch1;
    tmds_sym_t   tmds_ch2;
    pos_t        pos_red;
    pos_t        pos_green;
    pos_t        pos_blue;

    int          tr_frame[$];
    logic        tr_load[$];
    speed_load_t tr_speed[$];
    pos_t        tr_red[$];
    pos_t        tr_green[$];
    pos_t        tr_blue[$];
    int          frames_in_trace = 0;
    pos_t        shown[3];                  // positions drawn in the current frame
    int          sq_size[3] = '{8, 12, 16};
    string       colour_tag[3] = '{"red pixel", "green pixel", "blue pixel"};
    int          balance[3];                // ones minus zeros per line
    int          sym_x = 0;                 // screen coordinate of the symbols on the outputs
    int          sym_y = 0;
    logic        locked = 1'b0;

    bounce_top #(
        .H_RES(H_RES), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_RES(V_RES), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP),
        .RED_SIZE(8), .GREEN_SIZE(12), .BLUE_SIZE(16),
        .RED_X(0), .RED_Y(0), .GREEN_X(16), .GREEN_Y(8), .BLUE_X(32), .BLUE_Y(16),
        .RED_SPD(4), .GREEN_SPD(2), .BLUE_SPD(2)
    ) dut0 (
        .clk_pix, .reset, .speed_stb, .speed, .tmds_ch0, .tmds_ch1, .tmds_ch2,
        .pos_red, .pos_green, .pos_blue
    );

    always #(CLK_PERIOD / 2) clk_pix = ~clk_pix;

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %0h, actual %0h at %0t", name, expected, actual, $time);
            $display("Test FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    // inverse of the transition minimisation
    function automatic logic [7:0] tmds_decode(tmds_sym_t s);
        logic [7:0] d;
        logic [7:0] q;
        d = s[9] ? ~s[7:0] : s[7:0];
        q[0] = d[0];
        for (int i = 1; i < 8; i++)
            q[i] = s[8] ? (d[i] ^ d[i-1]) : ~(d[i] ^ d[i-1]);
        return q;
    endfunction

    function automatic logic is_ctrl(tmds_sym_t s);
        return (s == TMDS_CTRL_00) || (s == TMDS_CTRL_01) ||
               (s == TMDS_CTRL_10) || (s == TMDS_CTRL_11);
    endfunction

    function automatic tmds_sym_t sync_token(logic vs, logic hs);
        case ({vs, hs})
            2'b00:   return TMDS_CTRL_00;
            2'b01:   return TMDS_CTRL_01;
            2'b10:   return TMDS_CTRL_10;
            default: return TMDS_CTRL_11;
        endcase
    endfunction

    function automatic logic [7:0] square_byte(pos_t p, int size, int x, int y);
        int px;
        int py;
        px = int'(p.x);
        py = int'(p.y);
        return (x >= px && x < px + size && y >= py && y < py + size) ? 8'hFF : 8'h00;
    endfunction

    task automatic load_trace();
        int fd;
        int code;
        int f, ld, sr, sg, sb, rx, ry, gx, gy, bx, by;
        logic [8*128-1:0] skip;
        fd = $fopen("bounce_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file bounce_trace.txt");
            $display("Test FAILED");
            $fatal(1, "no trace");
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%d %d %d %d %d %d %d %d %d %d %d\n",
                               f, ld, sr, sg, sb, rx, ry, gx, gy, bx, by);
                if (code == 11) begin
                    tr_frame.push_back(f);
                    tr_load.push_back(ld != 0);
                    tr_speed.push_back({coord_t'(sr), coord_t'(sg), coord_t'(sb)});
                    tr_red.push_back({coord_t'(rx), coord_t'(ry)});
                    tr_green.push_back({coord_t'(gx), coord_t'(gy)});
                    tr_blue.push_back({coord_t'(bx), coord_t'(by)});
                end else begin
                    code = $fgets(skip, fd);    // comment line
                end
            end
            $fclose(fd);
            if (tr_frame.size() == 0) begin
                $display("the trace file holds no frames");
                $display("Test FAILED");
                $fatal(1, "empty trace");
            end else begin
                frames_in_trace = tr_frame[tr_frame.size() - 1];
            end
        end
    endtask

    // returns one cycle after the edge that applied the strobe
    task automatic wait_frame_stb();
        @(negedge clk_pix);
        while (dut0.frame_stb !== 1'b1)
            @(negedge clk_pix);
        @(posedge clk_pix);
        #1;
    endtask

    task automatic check_symbols(input int x, input int y);
        logic      hs;
        logic      vs;
        tmds_sym_t syms[3];
        hs = (x >= H_RES + H_FP) && (x < H_RES + H_FP + H_SYNC);
        vs = (y >= V_RES + V_FP) && (y < V_RES + V_FP + V_SYNC);
        syms[0] = tmds_ch2;     // red
        syms[1] = tmds_ch1;     // green
        syms[2] = tmds_ch0;     // blue
        if (x < H_RES && y < V_RES) begin
            if (x == 0)
                balance = '{0, 0, 0};
            for (int c = 0; c < 3; c++) begin
                check_equal("data symbol in active area", 0, 32'(is_ctrl(syms[c])));
                check_equal(colour_tag[c], 32'(square_byte(shown[c], sq_size[c], x, y)),
                            32'(tmds_decode(syms[c])));
                balance[c] += 2 * $countones(syms[c]) - 10;
                check_equal("dc balance within 8", 1,
                            32'(balance[c] >= -8 && balance[c] <= 8));
            end
        end else begin
            check_equal("ch0 sync token", 32'(sync_token(vs, hs)), 32'(tmds_ch0));
            check_equal("ch1 blanking token", 32'(TMDS_CTRL_00), 32'(tmds_ch1));
            check_equal("ch2 blanking token", 32'(TMDS_CTRL_00), 32'(tmds_ch2));
        end
    endtask

    // symbols trail sx/sy by two cycles, so the strobe marks pixel (78,47)
    always @(negedge clk_pix) begin
        int nx;
        int ny;
        nx = (sym_x == H_TOTAL - 1) ? 0 : sym_x + 1;
        ny = (sym_x != H_TOTAL - 1) ? sym_y : ((sym_y == V_TOTAL - 1) ? 0 : sym_y + 1);
        if (!reset && dut0.frame_stb) begin
            if (locked) begin
                check_equal("frame strobe x", H_TOTAL - 2, nx);
                check_equal("frame strobe y", V_RES - 1, ny);
            end
            locked = 1'b1;
            nx = H_TOTAL - 2;
            ny = V_RES - 1;
        end
        sym_x = nx;
        sym_y = ny;
        if (locked)
            check_symbols(sym_x, sym_y);
    end

    initial begin
        longint limit;
        wait (frames_in_trace > 0);
        limit = 2 * longint'(frames_in_trace) * FRAME_CYCLES * CLK_PERIOD;
        #(limit);
        $display("simulation timed out before the last trace frame was reached");
        $display("Test FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        int wait_cycles;
        void'($urandom(32'h079a_cd0a));
        reset = 1'b1;
        speed_stb = 1'b0;
        speed = '0;
        shown[0] = {coord_t'(0), coord_t'(0)};
        shown[1] = {coord_t'(16), coord_t'(8)};
        shown[2] = {coord_t'(32), coord_t'(16)};
        load_trace();
        repeat (2) @(posedge clk_pix);
        #1;
        reset = 1'b0;
        for (int i = 0; i < tr_frame.size(); i++) begin
            if (tr_load[i]) begin
                // strobe lands somewhere in the active lines of this frame
                wait_cycles = VBLANK_CYCLES + int'($urandom % 3700);
                repeat (wait_cycles) @(posedge clk_pix);
                #1;
                speed_stb = 1'b1;
                speed = tr_speed[i];
                @(posedge clk_pix);
                #1;
                speed_stb = 1'b0;
                check_equal("red held after speed load", 32'(shown[0]), 32'(pos_red));
                check_equal("green held after speed load", 32'(shown[1]), 32'(pos_green));
                check_equal("blue held after speed load", 32'(shown[2]), 32'(pos_blue));
            end
            wait_frame_stb();
            check_equal($sformatf("frame %0d red position", tr_frame[i]),
                        32'(tr_red[i]), 32'(pos_red));
            check_equal($sformatf("frame %0d green position", tr_frame[i]),
                        32'(tr_green[i]), 32'(pos_green));
            check_equal($sformatf("frame %0d blue position", tr_frame[i]),
                        32'(tr_blue[i]), 32'(pos_blue));
            shown[0] = tr_red[i];
            shown[1] = tr_green[i];
            shown[2] = tr_blue[i];
        end
        $display("Test OK");
        $finish;
    end

endmodule

// File: bounce_trace.txt
# frame load spd_red spd_green spd_blue red_x red_y green_x green_y blue_x blue_y
# positions are top-left corners after the frame strobe that ends each frame
1 0 0 0 0 4 4 18 10 34 18
2 0 0 0 0 8 8 20 12 36 20
3 0 0 0 0 12 12 22 14 38 22
4 0 0 0 0 16 16 24 16 40 24
5 0 0 0 0 20 20 26 18 42 26
6 1 6 4 5 26 26 30 22 47 31
7 0 0 0 0 32 32 34 26 42 26
8 0 0 0 0 38 38 38 30 37 21
9 0 0 0 0 44 32 42 34 32 16
10 0 0 0 0 50 26 46 30 27 11
11 0 0 0 0 44 20 50 26 22 6
12 0 0 0 0 38 14 46 22 17 1
13 0 0 0 0 32 8 42 18 12 6
14 1 3 7 3 29 5 35 11 9 9
15 0 0 0 0 26 2 28 4 6 12
16 0 0 0 0 23 5 21 11 3 15
17 0 0 0 0 20 8 14 18 0 18
18 0 0 0 0 17 11 7 25 3 21
19 0 0 0 0 14 14 0 32 6 24
20 0 0 0 0 11 17 7 25 9 27

// File: sim.f
bounce_pkg.sv
display_timings.sv
square_mover.sv
pixel_composer.sv
tmds_encoder.sv
bounce_top.sv
tb_bounce.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the bouncing squares testbench with Verilator and run it
# the run passes only if the testbench prints its pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_bounce \
    -f sim.f --Mdir obj_dir -o tb_bounce \
    && ./obj_dir/tb_bounce | tee /dev/stderr | grep -qx "Test OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

exit 0
